//--- Makefile
VERILATOR ?= verilator
TOP       ?= mips_cpu_control_unit_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timescale 1ns/1ps -j $(JOBS)
PASS_TEXT ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+verification
src/mips_isa_pkg.sv
src/mips_control_pkg.sv
src/mips_cpu_sequencer.sv
src/mips_cpu_instruction_register.sv
src/mips_cpu_controller.sv
src/mips_cpu_control_unit.sv
verification/mips_cpu_control_unit_tb.sv

//--- src/mips_control_pkg.sv
`default_nettype none

package mips_control_pkg;

    typedef enum logic [2:0] {
        HALTED = 3'd0,
        FETCH  = 3'd1,
        DECODE = 3'd2,
        EXEC1  = 3'd3,
        EXEC2  = 3'd4
    } phase_t;

    typedef logic [3:0] aluop_t;
    typedef logic [2:0] alusrcb_t;
    typedef logic [1:0] pcsource_t;
    typedef logic [1:0] regdst_t;
    typedef logic [1:0] loadtype_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [1:0] lane_t;

    // ALU operations
    localparam aluop_t ALU_ADD   = 4'd0;
    localparam aluop_t ALU_RTYPE = 4'd2;  // ALU decodes fncode itself
    localparam aluop_t ALU_EQ    = 4'd3;
    localparam aluop_t ALU_GEZ   = 4'd4;
    localparam aluop_t ALU_GTZ   = 4'd5;
    localparam aluop_t ALU_LEZ   = 4'd6;
    localparam aluop_t ALU_LTZ   = 4'd7;
    localparam aluop_t ALU_NE    = 4'd8;
    localparam aluop_t ALU_HILO  = 4'd9;
    localparam aluop_t ALU_AND   = 4'd10;
    localparam aluop_t ALU_OR    = 4'd11;
    localparam aluop_t ALU_XOR   = 4'd12;
    localparam aluop_t ALU_SLT   = 4'd13;
    localparam aluop_t ALU_SLTU  = 4'd14;

    // ALU B operand
    localparam alusrcb_t SRCB_REG       = 3'd0;
    localparam alusrcb_t SRCB_FOUR      = 3'd1;
    localparam alusrcb_t SRCB_SIGNIMM   = 3'd2;
    localparam alusrcb_t SRCB_BRANCHOFF = 3'd3;  // Sign-extended imm << 2
    localparam alusrcb_t SRCB_ZEROIMM   = 3'd4;

    // Next PC
    localparam pcsource_t PCSRC_ALU     = 2'd0;
    localparam pcsource_t PCSRC_ALUOUT  = 2'd1;
    localparam pcsource_t PCSRC_JTARGET = 2'd2;
    localparam pcsource_t PCSRC_REG     = 2'd3;

    // Register write destination
    localparam regdst_t REGDST_RT = 2'd0;
    localparam regdst_t REGDST_RD = 2'd1;
    localparam regdst_t REGDST_RA = 2'd2;  // $31

    localparam loadtype_t LOAD_ZERO_EXT = 2'd0;
    localparam loadtype_t LOAD_SIGN_EXT = 2'd1;
    localparam loadtype_t LOAD_UPPER    = 2'd2;

endpackage

`default_nettype wire

//--- src/mips_cpu_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_control_unit (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     run,
    input  mips_isa_pkg::instr_t          readdata,
    input  wire logic                     waitrequest,
    input  mips_isa_pkg::addr_t           memoryadress,
    output mips_control_pkg::phase_t      phase,
    output mips_control_pkg::regdst_t     regdst,
    output mips_control_pkg::lane_t       shiftdata,
    output mips_control_pkg::loadtype_t   loadtype,
    output logic                          regwrite,
    output logic                          iord,
    output logic                          irwrite,
    output logic                          pcwrite,
    output mips_control_pkg::pcsource_t   pcsource,
    output logic                          pcwritecond,
    output logic                          jump,
    output logic                          jumpconen,
    output logic                          threestate,
    output logic                          memread,
    output logic                          memwrite,
    output mips_control_pkg::byte_en_t    byteenable,
    output logic                          memtoreg,
    output mips_control_pkg::aluop_t      aluop,
    output logic                          muldivwrite,
    output logic                          alusrca,
    output mips_control_pkg::alusrcb_t    alusrcb,
    output logic                          aluouten
);

    import mips_isa_pkg::*;

    opcode_t opcode;
    fncode_t fncode;
    regimm_t regimm;

    mips_cpu_sequencer mips_cpu_sequencer_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .waitrequest (waitrequest),
        .opcode      (opcode),
        .regimm      (regimm),
        .phase       (phase)
    );

    mips_cpu_instruction_register mips_cpu_instruction_register_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .phase       (phase),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .opcode      (opcode),
        .fncode      (fncode),
        .regimm      (regimm)
    );

    mips_cpu_controller mips_cpu_controller_inst (
        .phase        (phase),
        .waitrequest  (waitrequest),
        .opcode       (opcode),
        .fncode       (fncode),
        .regimm       (regimm),
        .memoryadress (memoryadress),
        .regdst       (regdst),
        .shiftdata    (shiftdata),
        .loadtype     (loadtype),
        .regwrite     (regwrite),
        .iord         (iord),
        .irwrite      (irwrite),
        .pcwrite      (pcwrite),
        .pcsource     (pcsource),
        .pcwritecond  (pcwritecond),
        .jump         (jump),
        .jumpconen    (jumpconen),
        .threestate   (threestate),
        .memread      (memread),
        .memwrite     (memwrite),
        .byteenable   (byteenable),
        .memtoreg     (memtoreg),
        .aluop        (aluop),
        .muldivwrite  (muldivwrite),
        .alusrca      (alusrca),
        .alusrcb      (alusrcb),
        .aluouten     (aluouten)
    );

endmodule

`default_nettype wire

//--- src/mips_cpu_controller.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_controller (
    input  mips_control_pkg::phase_t      phase,
    input  wire logic                     waitrequest,
    input  mips_isa_pkg::opcode_t         opcode,
    input  mips_isa_pkg::fncode_t         fncode,
    input  mips_isa_pkg::regimm_t         regimm,
    input  mips_isa_pkg::addr_t           memoryadress,
    output mips_control_pkg::regdst_t     regdst,
    output mips_control_pkg::lane_t       shiftdata,
    output mips_control_pkg::loadtype_t   loadtype,
    output logic                          regwrite,
    output logic                          iord,
    output logic                          irwrite,
    output logic                          pcwrite,
    output mips_control_pkg::pcsource_t   pcsource,
    output logic                          pcwritecond,
    output logic                          jump,
    output logic                          jumpconen,
    output logic                          threestate,
    output logic                          memread,
    output logic                          memwrite,
    output mips_control_pkg::byte_en_t    byteenable,
    output logic                          memtoreg,
    output mips_control_pkg::aluop_t      aluop,
    output logic                          muldivwrite,
    output logic                          alusrca,
    output mips_control_pkg::alusrcb_t    alusrcb,
    output logic                          aluouten
);

    import mips_isa_pkg::*;
    import mips_control_pkg::*;

    logic  exec1;
    logic  exec2;
    lane_t lane;

    assign exec1 = (phase == EXEC1);
    assign exec2 = (phase == EXEC2);
    assign lane  = memoryadress[1:0];

    always_comb begin
        regdst      = REGDST_RT;
        shiftdata   = '0;
        loadtype    = LOAD_ZERO_EXT;
        regwrite    = 1'b0;
        iord        = 1'b0;
        irwrite     = 1'b0;
        pcwrite     = 1'b0;
        pcsource    = PCSRC_ALU;
        pcwritecond = 1'b0;
        jump        = 1'b0;
        jumpconen   = 1'b0;
        threestate  = 1'b0;
        memread     = 1'b0;
        memwrite    = 1'b0;
        byteenable  = '0;
        memtoreg    = 1'b0;
        aluop       = ALU_ADD;
        muldivwrite = 1'b0;
        alusrca     = 1'b0;
        alusrcb     = SRCB_REG;
        aluouten    = 1'b0;

        unique case (phase)
            FETCH: begin
                irwrite   = 1'b1;
                memread   = 1'b1;
                pcwrite   = !waitrequest;  // PC + 4 once the word is in
                jumpconen = !waitrequest;
                alusrcb   = SRCB_FOUR;
                aluouten  = 1'b1;
            end
            DECODE: begin
                alusrcb  = SRCB_BRANCHOFF;  // Precompute branch target
                aluouten = 1'b1;
            end
            EXEC1, EXEC2: begin
                unique case (opcode)
                    OP_SPECIAL: begin
                        threestate = 1'b1;
                        aluouten   = 1'b1;
                        case (fncode)
                            FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                            FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU: begin
                                regdst   = REGDST_RD;
                                regwrite = 1'b1;
                                aluop    = ALU_RTYPE;
                                alusrca  = 1'b1;
                            end
                            FN_JR: begin
                                pcsource = PCSRC_REG;
                                jump     = 1'b1;
                            end
                            FN_JALR: begin
                                regdst   = REGDST_RD;
                                regwrite = 1'b1;  // Link is PC + 4
                                pcsource = PCSRC_REG;
                                jump     = 1'b1;
                                alusrcb  = SRCB_FOUR;
                            end
                            FN_MFHI, FN_MFLO: begin
                                regdst   = REGDST_RD;
                                regwrite = 1'b1;
                                aluop    = ALU_HILO;
                            end
                            FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                                aluop       = ALU_HILO;
                                alusrca     = 1'b1;
                                muldivwrite = 1'b1;
                            end
                            default: begin
                                threestate = 1'b0;
                                aluouten   = 1'b0;
                            end
                        endcase
                    end
                    OP_REGIMM: begin
                        pcsource = PCSRC_ALUOUT;
                        if ((regimm == RI_BLTZ) || (regimm == RI_BGEZ)) begin
                            pcwritecond = 1'b1;
                            threestate  = 1'b1;
                            aluop       = (regimm == RI_BLTZ) ? ALU_LTZ : ALU_GEZ;
                            alusrca     = 1'b1;
                            aluouten    = 1'b1;
                        end else if ((regimm == RI_BLTZAL) || (regimm == RI_BGEZAL)) begin
                            regdst      = REGDST_RA;
                            regwrite    = exec1;  // Link first
                            pcwritecond = exec2;  // Then branch
                            alusrca     = exec2;
                            alusrcb     = exec1 ? SRCB_FOUR : SRCB_REG;
                            if (exec2) begin
                                aluop = (regimm == RI_BLTZAL) ? ALU_LTZ : ALU_GEZ;
                            end
                        end
                    end
                    OP_J, OP_JAL: begin
                        regdst     = REGDST_RA;
                        regwrite   = (opcode == OP_JAL);
                        pcsource   = PCSRC_JTARGET;
                        jump       = 1'b1;
                        threestate = 1'b1;
                        alusrcb    = (opcode == OP_JAL) ? SRCB_FOUR : SRCB_REG;
                        aluouten   = 1'b1;
                    end
                    OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                        pcsource    = PCSRC_ALUOUT;
                        pcwritecond = 1'b1;
                        threestate  = 1'b1;
                        alusrca     = 1'b1;
                        aluouten    = 1'b1;
                        case (opcode)
                            OP_BEQ:  aluop = ALU_EQ;
                            OP_BNE:  aluop = ALU_NE;
                            OP_BLEZ: aluop = ALU_LEZ;
                            default: aluop = ALU_GTZ;
                        endcase
                    end
                    OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                        regwrite   = 1'b1;
                        threestate = 1'b1;
                        alusrca    = 1'b1;
                        aluouten   = 1'b1;
                        alusrcb    = SRCB_SIGNIMM;
                        case (opcode)
                            OP_ADDIU: aluop = ALU_ADD;
                            OP_SLTI:  aluop = ALU_SLT;
                            OP_SLTIU: aluop = ALU_SLTU;
                            OP_ANDI:  aluop = ALU_AND;
                            OP_ORI:   aluop = ALU_OR;
                            default:  aluop = ALU_XOR;
                        endcase
                        if ((opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI)) begin
                            alusrcb = SRCB_ZEROIMM;  // Logical ops zero-extend
                        end
                    end
                    OP_LUI: begin
                        loadtype   = LOAD_UPPER;
                        regwrite   = 1'b1;
                        threestate = 1'b1;
                        aluouten   = 1'b1;
                    end
                    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                        shiftdata = (opcode == OP_LW) ? 2'd0 : lane;
                        if ((opcode == OP_LB) || (opcode == OP_LH) || (opcode == OP_LW)) begin
                            loadtype = LOAD_SIGN_EXT;
                        end
                        regwrite = exec2;
                        memread  = exec1;
                        iord     = 1'b1;
                        memtoreg = 1'b1;
                        alusrca  = 1'b1;
                        alusrcb  = SRCB_SIGNIMM;
                        aluouten = 1'b1;
                    end
                    OP_SB, OP_SH, OP_SW: begin
                        shiftdata  = (opcode == OP_SW) ? 2'd0 : lane;
                        iord       = 1'b1;
                        threestate = 1'b1;
                        memwrite   = 1'b1;
                        alusrca    = 1'b1;
                        alusrcb    = SRCB_SIGNIMM;
                        aluouten   = 1'b1;
                        if (opcode == OP_SW) begin
                            byteenable = 4'b1111;
                        end else if (opcode == OP_SH) begin
                            byteenable = (lane == 2'd0) ? 4'b0011 : 4'b1100;
                        end else begin
                            byteenable = 4'b0001 << lane;  // One lane per byte
                        end
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/mips_cpu_instruction_register.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_instruction_register (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  mips_control_pkg::phase_t   phase,
    input  wire logic                  waitrequest,
    input  mips_isa_pkg::instr_t       readdata,
    output mips_isa_pkg::opcode_t      opcode,
    output mips_isa_pkg::fncode_t      fncode,
    output mips_isa_pkg::regimm_t      regimm
);

    import mips_isa_pkg::*;
    import mips_control_pkg::*;

    instr_t instr;
    logic   load;

    assign load = (phase == FETCH) && !waitrequest;  // Last fetch cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr <= '0;
        end else if (load) begin
            instr <= readdata;
        end
    end

    assign opcode = instr[31:26];
    assign regimm = instr[20:16];  // rt field
    assign fncode = instr[5:0];

endmodule

`default_nettype wire

//--- src/mips_cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_sequencer (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  run,
    input  wire logic                  waitrequest,
    input  mips_isa_pkg::opcode_t      opcode,
    input  mips_isa_pkg::regimm_t      regimm,
    output mips_control_pkg::phase_t   phase
);

    import mips_isa_pkg::*;
    import mips_control_pkg::*;

    phase_t phase_next;
    logic   is_load;
    logic   is_branch_link;
    logic   needs_exec2;

    assign is_load = (opcode == OP_LB) || (opcode == OP_LH) || (opcode == OP_LW) ||
                     (opcode == OP_LBU) || (opcode == OP_LHU);

    assign is_branch_link = (opcode == OP_REGIMM) &&
                            ((regimm == RI_BLTZAL) || (regimm == RI_BGEZAL));

    assign needs_exec2 = is_load || is_branch_link;

    always_comb begin
        phase_next = phase;
        unique case (phase)
            HALTED: begin
                if (run) begin
                    phase_next = FETCH;
                end
            end
            FETCH: begin
                if (!waitrequest) begin  // Stall until memory answers
                    phase_next = DECODE;
                end
            end
            DECODE: begin
                phase_next = EXEC1;
            end
            EXEC1: begin
                if (needs_exec2) begin
                    phase_next = EXEC2;
                end else begin
                    phase_next = run ? FETCH : HALTED;
                end
            end
            EXEC2: begin
                phase_next = run ? FETCH : HALTED;
            end
            default: begin
                phase_next = HALTED;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= HALTED;
        end else begin
            phase <= phase_next;
        end
    end

endmodule

`default_nettype wire

//--- src/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  fncode_t;
    typedef logic [4:0]  regimm_t;
    typedef logic [31:0] addr_t;

    // Major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2b;

    // SPECIAL function codes
    localparam fncode_t FN_SLL   = 6'h00;
    localparam fncode_t FN_SRL   = 6'h02;
    localparam fncode_t FN_SRA   = 6'h03;
    localparam fncode_t FN_SLLV  = 6'h04;
    localparam fncode_t FN_SRLV  = 6'h06;
    localparam fncode_t FN_SRAV  = 6'h07;
    localparam fncode_t FN_JR    = 6'h08;
    localparam fncode_t FN_JALR  = 6'h09;
    localparam fncode_t FN_MFHI  = 6'h10;
    localparam fncode_t FN_MTHI  = 6'h11;
    localparam fncode_t FN_MFLO  = 6'h12;
    localparam fncode_t FN_MTLO  = 6'h13;
    localparam fncode_t FN_MULT  = 6'h18;
    localparam fncode_t FN_MULTU = 6'h19;
    localparam fncode_t FN_DIV   = 6'h1a;
    localparam fncode_t FN_DIVU  = 6'h1b;
    localparam fncode_t FN_ADDU  = 6'h21;
    localparam fncode_t FN_SUBU  = 6'h23;
    localparam fncode_t FN_AND   = 6'h24;
    localparam fncode_t FN_OR    = 6'h25;
    localparam fncode_t FN_XOR   = 6'h26;
    localparam fncode_t FN_SLT   = 6'h2a;
    localparam fncode_t FN_SLTU  = 6'h2b;

    // REGIMM rt field
    localparam regimm_t RI_BLTZ   = 5'h00;
    localparam regimm_t RI_BGEZ   = 5'h01;
    localparam regimm_t RI_BLTZAL = 5'h10;
    localparam regimm_t RI_BGEZAL = 5'h11;

endpackage

`default_nettype wire

//--- verification/mips_cpu_control_vectors.svh
`ifndef MIPS_CPU_CONTROL_VECTORS_SVH
`define MIPS_CPU_CONTROL_VECTORS_SVH

// Row fields in order are instruction, address, fetch stalls, cycles up to the next fetch,
// flags {regwrite, jump, pcwritecond, memread, memwrite}, regdst, aluop, alusrcb,
// pcsource, byteenable and shiftdata, all as expected in exec1
typedef struct packed {
    instr_t     instr;
    addr_t      addr;
    int         stalls;
    int         cycles;  // 5 means exec2 is taken
    logic [4:0] flags;
    regdst_t    regdst;
    aluop_t     aluop;
    alusrcb_t   alusrcb;
    pcsource_t  pcsource;
    byte_en_t   byteenable;
    lane_t      shiftdata;
} vector_t;

localparam int NUM_VECTORS = 36;
localparam int DROP_ROW    = 23;  // LW, run drops during its decode

vector_t vectors [NUM_VECTORS] = '{
    '{32'h00221821, 32'h0, 0, 4, 5'b10000, 2'd1, 4'd2, 3'd0, 2'd0, 4'b0000, 2'd0},  // ADDU
    '{32'h00021080, 32'h0, 2, 4, 5'b10000, 2'd1, 4'd2, 3'd0, 2'd0, 4'b0000, 2'd0},  // SLL
    '{32'h03e00008, 32'h0, 0, 4, 5'b01000, 2'd0, 4'd0, 3'd0, 2'd3, 4'b0000, 2'd0},  // JR
    '{32'h0080f809, 32'h0, 1, 4, 5'b11000, 2'd1, 4'd0, 3'd1, 2'd3, 4'b0000, 2'd0},  // JALR
    '{32'h00002810, 32'h0, 0, 4, 5'b10000, 2'd1, 4'd9, 3'd0, 2'd0, 4'b0000, 2'd0},  // MFHI
    '{32'h00220018, 32'h0, 0, 4, 5'b00000, 2'd0, 4'd9, 3'd0, 2'd0, 4'b0000, 2'd0},  // MULT
    '{32'h24220005, 32'h0, 0, 4, 5'b10000, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0000, 2'd0},  // ADDIU
    '{32'h2c220005, 32'h0, 3, 4, 5'b10000, 2'd0, 4'd14, 3'd2, 2'd0, 4'b0000, 2'd0}, // SLTIU
    '{32'h302200ff, 32'h0, 0, 4, 5'b10000, 2'd0, 4'd10, 3'd4, 2'd0, 4'b0000, 2'd0}, // ANDI
    '{32'h382200ff, 32'h0, 0, 4, 5'b10000, 2'd0, 4'd12, 3'd4, 2'd0, 4'b0000, 2'd0}, // XORI
    '{32'h3c021234, 32'h0, 0, 4, 5'b10000, 2'd0, 4'd0, 3'd0, 2'd0, 4'b0000, 2'd0},  // LUI
    '{32'h08000010, 32'h0, 0, 4, 5'b01000, 2'd2, 4'd0, 3'd0, 2'd2, 4'b0000, 2'd0},  // J
    '{32'h0c000010, 32'h0, 1, 4, 5'b11000, 2'd2, 4'd0, 3'd1, 2'd2, 4'b0000, 2'd0},  // JAL
    '{32'h10220004, 32'h0, 0, 4, 5'b00100, 2'd0, 4'd3, 3'd0, 2'd1, 4'b0000, 2'd0},  // BEQ
    '{32'h14220004, 32'h0, 0, 4, 5'b00100, 2'd0, 4'd8, 3'd0, 2'd1, 4'b0000, 2'd0},  // BNE
    '{32'h18200004, 32'h0, 0, 4, 5'b00100, 2'd0, 4'd6, 3'd0, 2'd1, 4'b0000, 2'd0},  // BLEZ
    '{32'h1c200004, 32'h0, 0, 4, 5'b00100, 2'd0, 4'd5, 3'd0, 2'd1, 4'b0000, 2'd0},  // BGTZ
    '{32'h04200004, 32'h0, 0, 4, 5'b00100, 2'd0, 4'd7, 3'd0, 2'd1, 4'b0000, 2'd0},  // BLTZ
    '{32'h04210004, 32'h0, 0, 4, 5'b00100, 2'd0, 4'd4, 3'd0, 2'd1, 4'b0000, 2'd0},  // BGEZ
    '{32'h04300004, 32'h0, 0, 5, 5'b10000, 2'd2, 4'd0, 3'd1, 2'd1, 4'b0000, 2'd0},  // BLTZAL
    '{32'h04310004, 32'h0, 1, 5, 5'b10000, 2'd2, 4'd0, 3'd1, 2'd1, 4'b0000, 2'd0},  // BGEZAL
    '{32'h80220003, 32'h1003, 0, 5, 5'b00010, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0000, 2'd3},  // LB
    '{32'h84220002, 32'h1002, 1, 5, 5'b00010, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0000, 2'd2},  // LH
    '{32'h8c220000, 32'h1002, 0, 5, 5'b00010, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0000, 2'd0},  // LW
    '{32'h90220001, 32'h1001, 2, 5, 5'b00010, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0000, 2'd1},  // LBU
    '{32'h94220000, 32'h1000, 0, 5, 5'b00010, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0000, 2'd0},  // LHU
    '{32'ha0220000, 32'h1000, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0001, 2'd0},  // SB
    '{32'ha0220001, 32'h1001, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0010, 2'd1},  // SB
    '{32'ha0220002, 32'h1002, 1, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0100, 2'd2},  // SB
    '{32'ha0220003, 32'h1003, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b1000, 2'd3},  // SB
    '{32'ha4220000, 32'h1000, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b0011, 2'd0},  // SH
    '{32'ha4220001, 32'h1001, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b1100, 2'd1},  // SH
    '{32'ha4220002, 32'h1002, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b1100, 2'd2},  // SH
    '{32'ha4220003, 32'h1003, 2, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b1100, 2'd3},  // SH
    '{32'hac220000, 32'h1000, 0, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b1111, 2'd0},  // SW
    '{32'hac220003, 32'h1003, 1, 4, 5'b00001, 2'd0, 4'd0, 3'd2, 2'd0, 4'b1111, 2'd0}   // SW
};

`endif

//--- verification/mips_cpu_control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_control_unit_tb;

    import mips_isa_pkg::*;
    import mips_control_pkg::*;

    `include "mips_cpu_control_vectors.svh"

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    logic clk;
    logic arst_n;
    logic run;
    logic waitrequest;
    instr_t readdata;
    addr_t memoryadress;

    phase_t phase;
    regdst_t regdst;
    lane_t shiftdata;
    loadtype_t loadtype;
    pcsource_t pcsource;
    byte_en_t byteenable;
    aluop_t aluop;
    alusrcb_t alusrcb;
    logic regwrite, iord, irwrite, pcwrite, pcwritecond, jump, jumpconen;
    logic threestate, memread, memwrite, memtoreg, muldivwrite, alusrca, aluouten;

    int cycle_count = 0;
    int cycle_limit;

    mips_cpu_control_unit mips_cpu_control_unit_inst (.*);

    always #HALF_PERIOD clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("TB FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
        $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        stop_with_failure("a control output did not match its expected value");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_aluop(input string name, input aluop_t actual, input aluop_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_alusrcb(input string name, input alusrcb_t actual,
                                 input alusrcb_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_pcsource(input string name, input pcsource_t actual,
                                  input pcsource_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_regdst(input string name, input regdst_t actual,
                                input regdst_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_byteenable(input string name, input byte_en_t actual,
                                    input byte_en_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_lane(input string name, input lane_t actual, input lane_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_loadtype(input string name, input loadtype_t actual,
                                  input loadtype_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    task automatic check_phase(input string name, input phase_t actual, input phase_t expected);
        if (actual !== expected) begin
            report_mismatch(name, 32'(actual), 32'(expected));
        end
    endtask

    // Halted means every strobe and select at zero
    task automatic check_idle();
        check_phase("phase", phase, HALTED);
        check_regdst("regdst", regdst, REGDST_RT);
        check_lane("shiftdata", shiftdata, 2'd0);
        check_loadtype("loadtype", loadtype, LOAD_ZERO_EXT);
        check_bit("regwrite", regwrite, 1'b0);
        check_bit("iord", iord, 1'b0);
        check_bit("irwrite", irwrite, 1'b0);
        check_bit("pcwrite", pcwrite, 1'b0);
        check_pcsource("pcsource", pcsource, PCSRC_ALU);
        check_bit("pcwritecond", pcwritecond, 1'b0);
        check_bit("jump", jump, 1'b0);
        check_bit("jumpconen", jumpconen, 1'b0);
        check_bit("threestate", threestate, 1'b0);
        check_bit("memread", memread, 1'b0);
        check_bit("memwrite", memwrite, 1'b0);
        check_byteenable("byteenable", byteenable, 4'b0000);
        check_bit("memtoreg", memtoreg, 1'b0);
        check_aluop("aluop", aluop, ALU_ADD);
        check_bit("muldivwrite", muldivwrite, 1'b0);
        check_bit("alusrca", alusrca, 1'b0);
        check_alusrcb("alusrcb", alusrcb, SRCB_REG);
        check_bit("aluouten", aluouten, 1'b0);
    endtask

    // Entered at the falling edge of the cycle before FETCH
    task automatic run_vector(input vector_t v, input logic drop_run);
        int   s;
        logic last;

        @(posedge clk);
        memoryadress <= v.addr;
        waitrequest  <= (v.stalls != 0);
        readdata     <= (v.stalls != 0) ? ~v.instr : v.instr;  // Junk until memory answers
        for (s = 0; s <= v.stalls; s++) begin
            last = (s == v.stalls);
            if (s != 0) begin
                @(posedge clk);
                if (last) begin
                    waitrequest <= 1'b0;
                    readdata    <= v.instr;
                end
            end
            @(negedge clk);
            check_phase("phase", phase, FETCH);
            check_bit("irwrite", irwrite, 1'b1);
            check_bit("memread", memread, 1'b1);
            check_bit("pcwrite", pcwrite, last);
            check_bit("jumpconen", jumpconen, last);
            check_alusrcb("alusrcb", alusrcb, SRCB_FOUR);
        end

        @(posedge clk);
        readdata <= ~v.instr;  // Word must now come from the IR
        if (drop_run) begin
            run <= 1'b0;
        end
        @(negedge clk);
        check_phase("phase", phase, DECODE);
        check_alusrcb("alusrcb", alusrcb, SRCB_BRANCHOFF);

        @(posedge clk);
        @(negedge clk);
        check_phase("phase", phase, EXEC1);
        check_bit("regwrite", regwrite, v.flags[4]);
        check_bit("jump", jump, v.flags[3]);
        check_bit("pcwritecond", pcwritecond, v.flags[2]);
        check_bit("memread", memread, v.flags[1]);
        check_bit("memwrite", memwrite, v.flags[0]);
        check_regdst("regdst", regdst, v.regdst);
        check_aluop("aluop", aluop, v.aluop);
        check_alusrcb("alusrcb", alusrcb, v.alusrcb);
        check_pcsource("pcsource", pcsource, v.pcsource);
        check_byteenable("byteenable", byteenable, v.byteenable);
        check_lane("shiftdata", shiftdata, v.shiftdata);

        if (v.cycles == 5) begin
            @(posedge clk);
            @(negedge clk);
            check_phase("phase", phase, EXEC2);
            check_bit("regwrite", regwrite, v.flags[1]);  // Load writes back now
            check_bit("pcwritecond", pcwritecond, !v.flags[1]);  // Link branch resolves
            check_bit("memread", memread, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_limit);
            stop_with_failure("simulation ran past its cycle limit");
        end
    end

    initial begin
        cycle_limit = RESET_CYCLES;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            cycle_limit += 2 * (5 + vectors[i].stalls);
        end
        clk          = 1'b0;
        arst_n       = 1'b0;
        run          = 1'b0;
        waitrequest  = 1'b0;
        readdata     = '0;
        memoryadress = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        check_idle();  // Run seen on the next edge

        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(vectors[i], 1'b0);
        end

        run_vector(vectors[DROP_ROW], 1'b1);
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_idle();
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
